// File: dv/fetch_testdata.txt
// Count of program words, the words from address 0, then the count of vectors
// Vector columns: fetch_enable stall flush redirect_pc update_en update_pc update_taken
0000000D
00100093 // 0x00 addi x1
00200113 // 0x04 addi x2
002081B3 // 0x08 add x3
00C0006F // 0x0C jal +12
00400213 // 0x10 skipped
00500293 // 0x14 skipped
00600313 // 0x18 addi x6
00000863 // 0x1C beq +16
00700393 // 0x20 addi x7
00008067 // 0x24 jalr, plain fetch
FE0018E3 // 0x28 bne -16
00A00513 // 0x2C addi x10
FD1FF06F // 0x30 jal -48
0000001B
0 0 0 00000000 0 00000000 0 // idle
1 0 0 00000000 0 00000000 0 // 0x00
1 0 0 00000000 0 00000000 0 // 0x04
1 0 0 00000000 0 00000000 0 // 0x08
1 0 0 00000000 0 00000000 0 // 0x0C jal
1 0 0 00000000 0 00000000 0 // 0x18
1 0 0 00000000 0 00000000 0 // 0x1C untrained
1 0 0 00000000 1 0000001C 1 // 0x20, train taken
1 1 0 00000000 1 0000001C 1 // stall, train taken
1 1 0 00000000 0 00000000 0 // stall
1 0 0 00000000 0 00000000 0 // 0x24 after stall
1 0 0 00000000 0 00000000 0 // 0x28 untrained
1 0 0 00000000 0 00000000 0 // 0x2C
1 0 0 00000000 0 00000000 0 // 0x30 jal back
1 0 1 00000018 0 00000000 0 // flush
1 1 1 0000001C 0 00000000 0 // flush with stall
1 0 0 00000000 0 00000000 0 // 0x1C taken
1 0 0 00000000 1 0000001C 0 // 0x2C, train not taken
1 0 0 00000000 1 0000001C 0 // 0x30, train not taken
1 0 1 0000001C 0 00000000 0 // flush to branch
1 0 0 00000000 0 00000000 0 // 0x1C falls through
0 0 0 00000000 1 00000028 1 // idle, train bne
1 0 0 00000000 1 00000028 1 // 0x20, train bne
1 0 0 00000000 0 00000000 0 // 0x24
1 0 0 00000000 0 00000000 0 // 0x28 backward taken
1 0 0 00000000 0 00000000 0 // 0x18
1 0 1 00000000 0 00000000 0 // flush to 0

// File: flist.f
+incdir+include
hdl/fetch_pkg.sv
hdl/bp_if.sv
hdl/instr_mem.sv
hdl/instr_predecode.sv
hdl/branch_predictor.sv
hdl/fetch_ctrl.sv
hdl/fetch_top.sv
dv/fetch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --timescale 1ns/1ps \
    --top-module fetch_tb \
    --Mdir obj_dir \
    -o Vfetch_tb \
    -f flist.f

# Exit status of the pipe is from tee, the log decides
./obj_dir/Vfetch_tb 2>&1 | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// File: dv/fetch_tb.sv
/* Fetch front end testbench */

`timescale 1ns/1ps

`include "fetch_defs.svh"

module fetch_tb;
    import fetch_pkg::*;

    localparam int AW           = $clog2(`IMEM_DEPTH);
    localparam int BW           = $clog2(`BP_ENTRIES);
    localparam int RESET_CYCLES = 4;
    localparam int RAND_LEN     = 120;  // Random stall phase length in cycles
    localparam int TD_SIZE      = 1024;

    // DUT inputs
    logic           clk;
    logic           reset_n;
    logic           fetch_enable;
    logic           stall;
    logic           flush;
    word_t          redirect_pc;
    logic           update_en;
    word_t          update_pc;
    logic           update_taken;
    logic           load_en;
    logic [AW-1:0]  load_addr;
    word_t          load_data;

    // DUT outputs
    word_t          if_id_pc;
    word_t          if_id_instr;
    logic           if_id_valid;
    logic           if_id_pred_taken;

    logic [31:0]    tdata [TD_SIZE];    // Raw data file image
    word_t          image [`IMEM_DEPTH]; // Expected memory contents
    int             n_prog;
    int             n_vec;
    int             cycle_cnt;
    logic [31:0]    lfsr;

    // Reference model state
    word_t          m_pc;
    word_t          m_ifpc;
    word_t          m_instr;
    logic           m_valid;
    logic           m_pred;
    logic           have_data;          // IF/ID payload defined once set
    bp_cnt_e        m_cnt [`BP_ENTRIES];

    fetch_top dut0 (
        .clk              (clk),
        .reset_n          (reset_n),
        .fetch_enable     (fetch_enable),
        .stall            (stall),
        .flush            (flush),
        .redirect_pc      (redirect_pc),
        .update_en        (update_en),
        .update_pc        (update_pc),
        .update_taken     (update_taken),
        .load_en          (load_en),
        .load_addr        (load_addr),
        .load_data        (load_data),
        .if_id_pc         (if_id_pc),
        .if_id_instr      (if_id_instr),
        .if_id_valid      (if_id_valid),
        .if_id_pred_taken (if_id_pred_taken)
    );

    always #50 clk = ~clk; // 100 ns period

    // Galois LFSR with x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic take_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_step(lfsr); // One step per bit
    endtask

    // B-type offset per the RV32 encoding
    function automatic word_t b_offset(input word_t w);
        logic [12:0] off;
        off = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        return {{19{off[12]}}, off};
    endfunction

    // J-type offset per the RV32 encoding
    function automatic word_t j_offset(input word_t w);
        logic [20:0] off;
        off = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        return {{11{off[20]}}, off};
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
            $display("*** FAILED ***");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
            $display("*** FAILED ***");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic init_model();
        m_pc      = `RESET_PC;
        m_valid   = 1'b0;
        m_pred    = 1'b0;
        have_data = 1'b0;
        for (int i = 0; i < `BP_ENTRIES; i++) begin
            m_cnt[i] = WEAK_NT;
        end
    endtask

    // One clock edge of the fetch rules
    task automatic step_model(input logic fe, input logic st, input logic fl, input word_t rpc,
                              input logic ue, input word_t upc, input logic ut);
        word_t         w;
        word_t         off;
        logic          is_br;
        logic          is_jal;
        logic          take;
        logic          go;
        logic [BW-1:0] ui;
        logic [1:0]    c;
        bp_cnt_e       cq;
        w      = image[m_pc[AW+1:2]];
        is_br  = (opcode_e'(w[6:0]) == OP_BRANCH);
        is_jal = (opcode_e'(w[6:0]) == OP_JAL);
        off    = is_jal ? j_offset(w) : b_offset(w);
        // Prediction reads the table before this edge's update
        cq     = m_cnt[m_pc[BW+1:2]];
        take   = is_jal || (is_br && (cq == WEAK_T || cq == STRONG_T));
        go     = fe && !st && !fl;
        m_valid = go;
        m_pred  = go && take;
        if (go) begin
            m_ifpc    = m_pc;
            m_instr   = w;
            have_data = 1'b1;
        end
        if (fl) begin
            m_pc = rpc;              // Flush wins over stall
        end else if (go) begin
            m_pc = take ? m_pc + off : m_pc + 32'd4;
        end
        if (ue) begin
            ui = upc[BW+1:2];
            c  = m_cnt[ui];
            if (ut && c != 2'b11) begin
                c = c + 2'd1;
            end else if (!ut && c != 2'b00) begin
                c = c - 2'd1;
            end
            m_cnt[ui] = bp_cnt_e'(c);
        end
    endtask

    // Drive one vector and compare after the edge
    task automatic run_cycle(input logic fe, input logic st, input logic fl, input word_t rpc,
                             input logic ue, input word_t upc, input logic ut);
        fetch_enable = fe;
        stall        = st;
        flush        = fl;
        redirect_pc  = rpc;
        update_en    = ue;
        update_pc    = upc;
        update_taken = ut;
        if (reset_n) begin
            step_model(fe, st, fl, rpc, ue, upc, ut);
        end
        @(posedge clk);
        #1;
        check_bit("if_id_valid", if_id_valid, m_valid);
        check_bit("if_id_pred_taken", if_id_pred_taken, m_pred);
        if (have_data) begin
            check_word("if_id_pc", if_id_pc, m_ifpc);
            check_word("if_id_instr", if_id_instr, m_instr);
        end
        cycle_cnt++;
        if (cycle_cnt == RESET_CYCLES) begin
            reset_n = 1'b1;          // Release 1 ns after the 4th edge
        end
    endtask

    initial begin
        int   base;
        int   k;
        logic b0;
        logic b1;
        logic b2;
        logic b3;
        clk          = 1'b0;
        reset_n      = 1'b0;
        fetch_enable = 1'b0;
        stall        = 1'b0;
        flush        = 1'b0;
        redirect_pc  = '0;
        update_en    = 1'b0;
        update_pc    = '0;
        update_taken = 1'b0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        cycle_cnt    = 0;
        lfsr         = 32'hf890;
        init_model();

        $readmemh("dv/fetch_testdata.txt", tdata);
        n_prog = int'(tdata[0]);
        n_vec  = int'(tdata[n_prog + 1]);
        base   = n_prog + 2;         // First vector word
        if (n_prog < 1 || n_prog > `IMEM_DEPTH || base + 7 * n_vec > TD_SIZE) begin
            $display("Test data file is missing or has bad word or vector counts");
            $display("*** FAILED ***");
            $fatal(1, "Bad test data");
        end

        // Loader runs across reset with fetch off
        for (int i = 0; i < n_prog; i++) begin
            image[i]  = tdata[i + 1];
            load_en   = 1'b1;
            load_addr = AW'(i);
            load_data = tdata[i + 1];
            run_cycle(1'b0, 1'b0, 1'b0, '0, 1'b0, '0, 1'b0);
        end
        load_en = 1'b0;

        // Directed vectors from the data file
        for (int v = 0; v < n_vec; v++) begin
            k = base + 7 * v;
            run_cycle(tdata[k][0], tdata[k + 1][0], tdata[k + 2][0], tdata[k + 3],
                      tdata[k + 4][0], tdata[k + 5], tdata[k + 6][0]);
        end

        // Random stalls and fetch_enable gaps
        for (int r = 0; r < RAND_LEN; r++) begin
            take_bit(b0);
            take_bit(b1);
            take_bit(b2);
            take_bit(b3);
            run_cycle(b0 | b1, b2 & b3, 1'b0, '0, 1'b0, '0, 1'b0);
        end

        $display("*** PASSED ***");
        $finish;
    end

    // Watchdog sized from the test length
    initial begin
        int limit;
        #1;
        limit = RESET_CYCLES + n_prog + n_vec + RAND_LEN + 20;
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the test did not complete", limit);
        $display("*** FAILED ***");
        $fatal(1, "Timeout");
    end

endmodule

// File: hdl/fetch_top.sv
/* Instruction fetch front end */

`timescale 1ns/1ps

`include "fetch_defs.svh"

module fetch_top (
    input  logic                           clk,
    input  logic                           reset_n,
    // Pipeline control
    input  logic                           fetch_enable,
    input  logic                           stall,
    input  logic                           flush,
    input  fetch_pkg::word_t               redirect_pc,
    // Resolve feedback from execute
    input  logic                           update_en,
    input  fetch_pkg::word_t               update_pc,
    input  logic                           update_taken,
    // Program loader
    input  logic                           load_en,
    input  logic [$clog2(`IMEM_DEPTH)-1:0] load_addr,
    input  fetch_pkg::word_t               load_data,
    // IF/ID register
    output fetch_pkg::word_t               if_id_pc,
    output fetch_pkg::word_t               if_id_instr,
    output logic                           if_id_valid,
    output logic                           if_id_pred_taken
);
    import fetch_pkg::*;

    word_t        pc;          // Current fetch address
    word_t        rdata;       // Fetched word
    instr_class_e instr_class;
    word_t        immediate;

    bp_if bp0 ();

    // Resolve side of the predictor link
    assign bp0.update_en    = update_en;
    assign bp0.update_pc    = update_pc;
    assign bp0.update_taken = update_taken;

    instr_mem imem0 (
        .clk       (clk),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .pc        (pc),
        .rdata     (rdata)
    );

    instr_predecode pdec0 (
        .instr       (rdata),
        .instr_class (instr_class),
        .immediate   (immediate)
    );

    branch_predictor bpred0 (
        .clk     (clk),
        .reset_n (reset_n),
        .bp      (bp0.predictor)
    );

    fetch_ctrl fctl0 (
        .clk              (clk),
        .reset_n          (reset_n),
        .fetch_enable     (fetch_enable),
        .stall            (stall),
        .flush            (flush),
        .redirect_pc      (redirect_pc),
        .pc               (pc),
        .rdata            (rdata),
        .instr_class      (instr_class),
        .immediate        (immediate),
        .bp               (bp0.ctrl),
        .if_id_pc         (if_id_pc),
        .if_id_instr      (if_id_instr),
        .if_id_valid      (if_id_valid),
        .if_id_pred_taken (if_id_pred_taken)
    );

endmodule

// File: hdl/fetch_ctrl.sv
/* Fetch controller and IF/ID register */

`timescale 1ns/1ps

`include "fetch_defs.svh"

module fetch_ctrl (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    fetch_enable,    // Fetch allowed this cycle
    input  logic                    stall,           // Hold PC and IF/ID
    input  logic                    flush,           // Redirect beats stall
    input  fetch_pkg::word_t        redirect_pc,
    output fetch_pkg::word_t        pc,              // To instruction memory
    input  fetch_pkg::word_t        rdata,           // Word at pc
    input  fetch_pkg::instr_class_e instr_class,     // From predecode
    input  fetch_pkg::word_t        immediate,       // B or J offset
    bp_if.ctrl                      bp,
    output fetch_pkg::word_t        if_id_pc,
    output fetch_pkg::word_t        if_id_instr,
    output logic                    if_id_valid,
    output logic                    if_id_pred_taken // JAL or predicted branch
);
    import fetch_pkg::*;

    logic  fetch_go;  // Normal fetch this cycle
    logic  take_tgt;  // Follow the PC-relative target
    word_t seq_pc;    // Fall-through
    word_t tgt_pc;    // pc + offset
    word_t next_pc;

    // Predictor always looks at the current PC
    assign bp.query_pc = pc;

    // Flush beats stall and stall beats fetch
    assign fetch_go = fetch_enable && !stall && !flush;

    // Jumps always redirect and branches only when predicted
    always_comb begin
        case (instr_class)
            CLS_JUMP:   take_tgt = 1'b1;
            CLS_BRANCH: take_tgt = bp.predict_taken;
            default:    take_tgt = 1'b0; // JALR waits for redirect
        endcase
    end

    assign seq_pc  = pc + word_t'(4);
    assign tgt_pc  = pc + immediate;
    assign next_pc = take_tgt ? tgt_pc : seq_pc;

    // PC register
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc <= `RESET_PC;
        end else if (flush) begin
            pc <= redirect_pc;     // Restart from resolved target
        end else if (fetch_go) begin
            pc <= next_pc;
        end
        // Stall or idle holds pc
    end

    // IF/ID control bits
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            if_id_valid      <= 1'b0;
            if_id_pred_taken <= 1'b0;
        end else if (fetch_go) begin
            if_id_valid      <= 1'b1;
            if_id_pred_taken <= take_tgt;
        end else begin
            // Flush, stall and idle all give a bubble
            if_id_valid      <= 1'b0;
            if_id_pred_taken <= 1'b0;
        end
    end

    // IF/ID payload loads only on a real fetch
    always_ff @(posedge clk) begin
        if (fetch_go) begin
            if_id_pc    <= pc;
            if_id_instr <= rdata;
        end
    end

endmodule

// File: hdl/branch_predictor.sv
/* Bimodal branch predictor */

`timescale 1ns/1ps

`include "fetch_defs.svh"

module branch_predictor (
    input  logic clk,
    input  logic reset_n,
    bp_if.predictor bp
);
    import fetch_pkg::*;

    localparam int IDX_W = $clog2(`BP_ENTRIES);

    // Counter table
    bp_cnt_e cnt_tbl [`BP_ENTRIES];

    logic [IDX_W-1:0] q_idx;    // Lookup index
    logic [IDX_W-1:0] u_idx;    // Training index
    bp_cnt_e          q_cnt;
    bp_cnt_e          u_cnt;
    bp_cnt_e          cnt_next; // Trained value

    // Word-aligned PC bits pick the entry
    assign q_idx = bp.query_pc[IDX_W+1:2];
    assign u_idx = bp.update_pc[IDX_W+1:2];

    assign q_cnt = cnt_tbl[q_idx];
    assign u_cnt = cnt_tbl[u_idx];

    // Taken on WEAK_T or STRONG_T
    // Lookup sees the old count during a same-cycle update
    assign bp.predict_taken = q_cnt[1];

    // One saturating step toward the resolved direction
    always_comb begin
        cnt_next = u_cnt;
        if (bp.update_taken) begin
            case (u_cnt)
                STRONG_NT: cnt_next = WEAK_NT;
                WEAK_NT:   cnt_next = WEAK_T;
                WEAK_T:    cnt_next = STRONG_T;
                default:   cnt_next = STRONG_T; // Already at the top
            endcase
        end else begin
            case (u_cnt)
                STRONG_T:  cnt_next = WEAK_T;
                WEAK_T:    cnt_next = WEAK_NT;
                WEAK_NT:   cnt_next = STRONG_NT;
                default:   cnt_next = STRONG_NT; // Already at the bottom
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            // Start every entry weakly not-taken
            for (int i = 0; i < `BP_ENTRIES; i++) begin
                cnt_tbl[i] <= WEAK_NT;
            end
        end else if (bp.update_en) begin
            cnt_tbl[u_idx] <= cnt_next; // Single-cycle resolve pulse
        end
    end

endmodule

// File: hdl/instr_predecode.sv
/* Fetch predecode and immediates */

`timescale 1ns/1ps

module instr_predecode (
    input  fetch_pkg::word_t        instr,       // Raw word from memory
    output fetch_pkg::instr_class_e instr_class,
    output fetch_pkg::word_t        immediate    // B or J offset or zero
);
    import fetch_pkg::*;

    opcode_e opcode;
    word_t   imm_b;
    word_t   imm_j;

    assign opcode = opcode_e'(instr[6:0]);

    // B-type offset with bit 0 always zero
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    // J-type offset sign extended from 21 bits
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        instr_class = CLS_OTHER;
        immediate   = '0;
        case (opcode)
            OP_BRANCH: begin
                instr_class = CLS_BRANCH;
                immediate   = imm_b;
            end
            OP_JAL: begin
                instr_class = CLS_JUMP; // Always taken and PC relative
                immediate   = imm_j;
            end
            // JALR resolves later through redirect
            default: begin
                instr_class = CLS_OTHER; // Plain fetch
            end
        endcase
    end

endmodule

// File: hdl/instr_mem.sv
/* Instruction memory */

`timescale 1ns/1ps

`include "fetch_defs.svh"

module instr_mem (
    input  logic                           clk,
    input  logic                           load_en,   // Write strobe from loader
    input  logic [$clog2(`IMEM_DEPTH)-1:0] load_addr, // Word address
    input  fetch_pkg::word_t               load_data,
    input  fetch_pkg::word_t               pc,        // Byte address from fetch
    output fetch_pkg::word_t               rdata      // Async read data
);
    import fetch_pkg::*;

    localparam int AW = $clog2(`IMEM_DEPTH);

    // Program storage
    word_t          mem [`IMEM_DEPTH];
    logic  [AW-1:0] rd_idx;

    // Word index wraps around the depth
    assign rd_idx = pc[AW+1:2];

    // Loader writes on the edge
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // Combinational read in the same cycle as PC
    assign rdata = mem[rd_idx];

endmodule

// File: hdl/bp_if.sv
/* Branch predictor link */

`timescale 1ns/1ps

interface bp_if;
    import fetch_pkg::*;

    word_t query_pc;      // Current fetch PC
    logic  predict_taken; // Counter MSB at query index
    logic  update_en;     // One-cycle resolve pulse
    word_t update_pc;     // PC of the resolved branch
    logic  update_taken;  // Resolved direction

    // Fetch side
    modport ctrl (
        output query_pc,
        input  predict_taken
    );

    // Counter table
    modport predictor (
        input  query_pc,
        input  update_en,
        input  update_pc,
        input  update_taken,
        output predict_taken
    );

    // Stand-in for the execute stage
    modport resolve (
        output update_en,
        output update_pc,
        output update_taken
    );

endinterface

// File: hdl/fetch_pkg.sv
/* Fetch front end types */

`include "fetch_defs.svh"

package fetch_pkg;

    // PC, instruction and immediate
    typedef logic [`XLEN-1:0] word_t;

    // RV32 major opcodes seen by predecode
    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011, // BEQ, BNE, BLT ...
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111, // Target needs rs1
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_OPIMM  = 7'b0010011,
        OP_OP     = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111
    } opcode_e;

    // What fetch cares about
    typedef enum logic [1:0] {
        CLS_OTHER  = 2'd0,
        CLS_BRANCH = 2'd1,
        CLS_JUMP   = 2'd2
    } instr_class_e;

    // 2-bit saturating counter with the prediction in the MSB
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } bp_cnt_e;

endpackage

// File: include/fetch_defs.svh
/* Fetch front end parameters */

`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Data path width
`define XLEN 32

// Instruction memory depth in words
`define IMEM_DEPTH 256

// Predictor table size with PC bits 7..2 as index
`define BP_ENTRIES 64

// First PC after reset
`define RESET_PC 32'h0000_0000

`endif
